// File: common/id_defs.svh
// decode stage widths and field positions
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

`define ID_WORD_W    32     // data and instruction width
`define ID_RADDR_W   3      // eight registers
`define ID_IMM_W     16     // immediate and branch offset width

// major opcode field
`define ID_OP_MSB    31
`define ID_OP_LSB    25
`define ID_S_BIT     28     // flag update bit of alu instructions

// register fields, each ID_RADDR_W wide
`define ID_RD_LSB    22     // destination or store source, bits 24:22
`define ID_RA_LSB    19     // first operand or pointer, bits 21:19
`define ID_RB_LSB    16     // second operand, bits 18:16

`define ID_COND_LSB  21     // branch condition, bits 24:21

// cpsr flag positions
`define ID_FLAG_N    31
`define ID_FLAG_Z    30
`define ID_FLAG_C    29
`define ID_FLAG_V    28

`endif

// File: common/isa_pkg.sv
// instruction set types
`include "id_defs.svh"

package isa_pkg;

    typedef logic [`ID_WORD_W-1:0]  word_t;
    typedef logic [`ID_RADDR_W-1:0] reg_addr_t;
    typedef logic [`ID_IMM_W-1:0]   imm_t;

    // major 7-bit encodings, don't-care bits are zero
    typedef enum logic [`ID_OP_MSB-`ID_OP_LSB:0] {
        OP_MOV   = 7'b0000000, OP_MOVT  = 7'b0000001,   // half-word moves
        OP_CLR   = 7'b0000010, OP_SET   = 7'b0000011,
        OP_LSL   = 7'b0000100, OP_LSR   = 7'b0000101,
        OP_ADD   = 7'b0010001, OP_SUB   = 7'b0010010,   // alu, immediate form
        OP_AND   = 7'b0010011, OP_OR    = 7'b0010100,
        OP_XOR   = 7'b0010101,
        OP_ADDS  = 7'b0011001, OP_SUBS  = 7'b0011010,   // same with flag update
        OP_ANDS  = 7'b0011011, OP_ORS   = 7'b0011100,
        OP_XORS  = 7'b0011101,
        OP_ADD2  = 7'b0110001, OP_SUB2  = 7'b0110010,   // alu, register form
        OP_AND2  = 7'b0110011, OP_OR2   = 7'b0110100,
        OP_XOR2  = 7'b0110101, OP_NOT   = 7'b0110110,
        OP_ADDS2 = 7'b0111001, OP_SUBS2 = 7'b0111010,
        OP_ANDS2 = 7'b0111011, OP_ORS2  = 7'b0111100,
        OP_XORS2 = 7'b0111101,
        OP_LOAD  = 7'b1000000, OP_STOR  = 7'b1000001,
        OP_B     = 7'b1100000, OP_BCOND = 7'b1100001,   // b and br decode as nop
        OP_BR    = 7'b1100010, OP_NOP   = 7'b1100100,
        OP_HALT  = 7'b1101000
    } opcode_e;

    // branch conditions, 12 to 15 unused
    typedef enum logic [3:0] {
        EQ = 4'd0,
        NE = 4'd1,
        CS = 4'd2,
        CC = 4'd3,
        MI = 4'd4,
        PL = 4'd5,
        VS = 4'd6,
        VC = 4'd7,
        HI = 4'd8,
        LS = 4'd9,
        GE = 4'd10,
        LT = 4'd11
    } cond_e;

endpackage

// File: common/ctrl_pkg.sv
// control types driven by the decode stage
package ctrl_pkg;

    // alu operation, same code as instruction bits 27:25
    typedef enum logic [2:0] {
        ALU_NOP = 3'd0,     // no alu instruction
        ALU_ADD = 3'd1,
        ALU_SUB = 3'd2,
        ALU_AND = 3'd3,
        ALU_OR  = 3'd4,
        ALU_XOR = 3'd5,
        ALU_NOT = 3'd6
    } alu_op_e;

    typedef enum logic {
        SRC_IMM = 1'b0,     // operand2 carries the immediate
        SRC_REG = 1'b1      // alu takes second register
    } opnd_src_e;

    typedef enum logic [1:0] {
        WR_ID  = 2'd0,      // write_data from this stage
        WR_ALU = 2'd1,
        WR_MEM = 2'd2       // register file takes memory read data
    } wr_src_e;

    // result select for values formed inside the stage
    typedef enum logic [2:0] {
        MK_NONE, MK_MOV, MK_MOVT, MK_LSL, MK_LSR, MK_CLR, MK_SET
    } mov_kind_e;

endpackage

// File: decoder/ctrl_decode.sv
// opcode decode into stage controls
`include "id_defs.svh"

module ctrl_decode (
    input  isa_pkg::word_t       instruction,
    output isa_pkg::reg_addr_t   read_addr1,          // combinational to register file
    output isa_pkg::reg_addr_t   read_addr2,
    output isa_pkg::reg_addr_t   write_addr_nxt,
    output ctrl_pkg::wr_src_e    write_data_sel_nxt,
    output logic                 write_enable_nxt,
    output logic                 wr_cpsr_nxt,
    output ctrl_pkg::alu_op_e    opcode_nxt,
    output ctrl_pkg::opnd_src_e  ir_op_nxt,
    output logic                 data_read_nxt,
    output logic                 data_write_nxt,
    output logic                 is_bcond,
    output logic                 halt_req,
    output ctrl_pkg::mov_kind_e  mov_kind
);

    isa_pkg::opcode_e   op;
    isa_pkg::reg_addr_t rd, ra, rb;
    logic               alu_imm, alu_reg;   // instruction class

    assign op = isa_pkg::opcode_e'(instruction[`ID_OP_MSB:`ID_OP_LSB]);
    assign rd = instruction[`ID_RD_LSB +: `ID_RADDR_W];
    assign ra = instruction[`ID_RA_LSB +: `ID_RADDR_W];
    assign rb = instruction[`ID_RB_LSB +: `ID_RADDR_W];

    always_comb begin : class_dec
        alu_imm        = 1'b0;
        alu_reg        = 1'b0;
        data_read_nxt  = 1'b0;
        data_write_nxt = 1'b0;
        is_bcond       = 1'b0;
        halt_req       = 1'b0;
        mov_kind       = ctrl_pkg::MK_NONE;
        case (op)
            isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_OR,
            isa_pkg::OP_XOR, isa_pkg::OP_ADDS, isa_pkg::OP_SUBS, isa_pkg::OP_ANDS,
            isa_pkg::OP_ORS, isa_pkg::OP_XORS: alu_imm = 1'b1;
            isa_pkg::OP_ADD2, isa_pkg::OP_SUB2, isa_pkg::OP_AND2, isa_pkg::OP_OR2,
            isa_pkg::OP_XOR2, isa_pkg::OP_NOT, isa_pkg::OP_ADDS2, isa_pkg::OP_SUBS2,
            isa_pkg::OP_ANDS2, isa_pkg::OP_ORS2, isa_pkg::OP_XORS2: alu_reg = 1'b1;
            isa_pkg::OP_MOV:   mov_kind = ctrl_pkg::MK_MOV;
            isa_pkg::OP_MOVT:  mov_kind = ctrl_pkg::MK_MOVT;
            isa_pkg::OP_LSL:   mov_kind = ctrl_pkg::MK_LSL;
            isa_pkg::OP_LSR:   mov_kind = ctrl_pkg::MK_LSR;
            isa_pkg::OP_CLR:   mov_kind = ctrl_pkg::MK_CLR;
            isa_pkg::OP_SET:   mov_kind = ctrl_pkg::MK_SET;
            isa_pkg::OP_LOAD:  data_read_nxt  = 1'b1;
            isa_pkg::OP_STOR:  data_write_nxt = 1'b1;
            isa_pkg::OP_BCOND: is_bcond = 1'b1;
            isa_pkg::OP_HALT:  halt_req = 1'b1;
            default: ;                              // nop, b, br and unknown codes
        endcase
    end

    always_comb begin : ctrl_set
        read_addr1         = '0;
        read_addr2         = '0;
        write_addr_nxt     = '0;
        write_data_sel_nxt = ctrl_pkg::WR_ID;
        write_enable_nxt   = 1'b0;
        wr_cpsr_nxt        = 1'b0;
        opcode_nxt         = ctrl_pkg::ALU_NOP;
        ir_op_nxt          = ctrl_pkg::SRC_IMM;
        if (alu_imm || alu_reg) begin
            read_addr1         = ra;
            write_addr_nxt     = rd;
            write_data_sel_nxt = ctrl_pkg::WR_ALU;
            write_enable_nxt   = 1'b1;
            wr_cpsr_nxt        = instruction[`ID_S_BIT];    // s variants set flags
            opcode_nxt = ctrl_pkg::alu_op_e'(instruction[`ID_OP_LSB +: 3]);
        end
        if (alu_reg) begin
            ir_op_nxt = ctrl_pkg::SRC_REG;
            if (op != isa_pkg::OP_NOT)
                read_addr2 = rb;                            // not is unary
        end
        if (mov_kind != ctrl_pkg::MK_NONE) begin
            write_addr_nxt   = rd;
            write_enable_nxt = 1'b1;                        // source stays WR_ID
            if (mov_kind == ctrl_pkg::MK_MOV || mov_kind == ctrl_pkg::MK_MOVT)
                read_addr1 = rd;                            // keep other half of rd
            else if (mov_kind == ctrl_pkg::MK_LSL || mov_kind == ctrl_pkg::MK_LSR)
                read_addr1 = ra;                            // shift source
        end
        if (data_read_nxt) begin
            read_addr1         = ra;                        // pointer register
            write_addr_nxt     = rd;
            write_data_sel_nxt = ctrl_pkg::WR_MEM;
            write_enable_nxt   = 1'b1;
        end
        if (data_write_nxt) begin
            read_addr1 = rd;                                // store source
            read_addr2 = ra;                                // pointer register
        end
    end

endmodule

// File: decoder/branch_unit.sv
// conditional branch evaluation
`include "id_defs.svh"

module branch_unit (
    input  isa_pkg::word_t  instruction,
    input  logic            is_bcond,
    input  isa_pkg::word_t  re_cpsr_val,
    input  isa_pkg::word_t  re_pc_val,
    output logic            wr_pc_nxt,
    output isa_pkg::word_t  wr_pc_val_nxt
);

    isa_pkg::cond_e cond;
    isa_pkg::word_t offset;                 // sign extended branch offset
    logic           n, z, c, v;
    logic           cond_ok, taken;

    assign cond   = isa_pkg::cond_e'(instruction[`ID_COND_LSB +: $bits(isa_pkg::cond_e)]);
    assign offset = {{(`ID_WORD_W-`ID_IMM_W){instruction[`ID_IMM_W-1]}},
                     instruction[`ID_IMM_W-1:0]};

    assign n = re_cpsr_val[`ID_FLAG_N];
    assign z = re_cpsr_val[`ID_FLAG_Z];
    assign c = re_cpsr_val[`ID_FLAG_C];
    assign v = re_cpsr_val[`ID_FLAG_V];

    always_comb begin
        case (cond)
            isa_pkg::EQ: cond_ok = z;
            isa_pkg::NE: cond_ok = ~z;
            isa_pkg::CS: cond_ok = c;
            isa_pkg::CC: cond_ok = ~c;
            isa_pkg::MI: cond_ok = n;
            isa_pkg::PL: cond_ok = ~n;
            isa_pkg::VS: cond_ok = v;
            isa_pkg::VC: cond_ok = ~v;
            isa_pkg::HI: cond_ok = c & ~z;
            isa_pkg::LS: cond_ok = ~(c & ~z);
            isa_pkg::GE: cond_ok = ~(n ^ v);    // signed compare on n and v
            isa_pkg::LT: cond_ok = n ^ v;
            default:     cond_ok = 1'b0;        // codes 12..15 never taken
        endcase
    end

    assign taken         = is_bcond & cond_ok;
    assign wr_pc_nxt     = taken;
    assign wr_pc_val_nxt = taken ? re_pc_val + offset : '0;

endmodule

// File: decoder/id_datapath.sv
// values formed inside the decode stage
`include "id_defs.svh"

module id_datapath (
    input  isa_pkg::word_t       instruction,
    input  isa_pkg::word_t       reg1_val,
    input  isa_pkg::word_t       reg2_val,
    input  ctrl_pkg::mov_kind_e  mov_kind,
    input  logic                 data_read_nxt,
    input  logic                 data_write_nxt,
    input  ctrl_pkg::wr_src_e    write_data_sel_nxt,
    input  ctrl_pkg::opnd_src_e  ir_op_nxt,
    output isa_pkg::word_t       write_data_nxt,
    output isa_pkg::word_t       data_addr_nxt,
    output isa_pkg::word_t       data_out_nxt,
    output isa_pkg::word_t       operand2_nxt
);

    isa_pkg::imm_t  imm;
    isa_pkg::word_t imm_ext;                // zero extended immediate
    isa_pkg::word_t base;
    logic           mem_acc;

    assign imm     = instruction[`ID_IMM_W-1:0];
    assign imm_ext = {{(`ID_WORD_W-`ID_IMM_W){1'b0}}, imm};

    always_comb begin
        case (mov_kind)
            ctrl_pkg::MK_MOV:  write_data_nxt = {reg1_val[`ID_WORD_W-1:`ID_IMM_W], imm};
            ctrl_pkg::MK_MOVT: write_data_nxt = {imm, reg1_val[`ID_IMM_W-1:0]};
            ctrl_pkg::MK_LSL:  write_data_nxt = reg1_val << imm;
            ctrl_pkg::MK_LSR:  write_data_nxt = reg1_val >> imm;
            ctrl_pkg::MK_CLR:  write_data_nxt = '0;
            ctrl_pkg::MK_SET:  write_data_nxt = '1;
            default:           write_data_nxt = '0;    // alu and memory sources
        endcase
    end

    // stores address through the second read port
    assign base          = data_write_nxt ? reg2_val : reg1_val;
    assign mem_acc       = data_read_nxt | data_write_nxt;
    assign data_addr_nxt = mem_acc ? base + imm_ext : '0;
    assign data_out_nxt  = data_write_nxt ? reg1_val : '0;

    // immediate operand only for alu immediate form
    assign operand2_nxt = (write_data_sel_nxt == ctrl_pkg::WR_ALU &&
                           ir_op_nxt == ctrl_pkg::SRC_IMM) ? imm_ext : '0;

endmodule

// File: decoder/id_out_stage.sv
// output register with sticky halt
module id_out_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 halt_req,
    input  isa_pkg::reg_addr_t   write_addr_nxt,
    input  isa_pkg::word_t       write_data_nxt,
    input  ctrl_pkg::wr_src_e    write_data_sel_nxt,
    input  logic                 write_enable_nxt,
    input  logic                 wr_cpsr_nxt,
    input  isa_pkg::word_t       data_addr_nxt,
    input  logic                 data_read_nxt,
    input  logic                 data_write_nxt,
    input  isa_pkg::word_t       data_out_nxt,
    input  ctrl_pkg::alu_op_e    opcode_nxt,
    input  isa_pkg::word_t       operand2_nxt,
    input  ctrl_pkg::opnd_src_e  ir_op_nxt,
    input  logic                 wr_pc_nxt,
    input  isa_pkg::word_t       wr_pc_val_nxt,
    output isa_pkg::reg_addr_t   write_addr,
    output isa_pkg::word_t       write_data,
    output ctrl_pkg::wr_src_e    write_data_sel,
    output logic                 write_enable,
    output logic                 wr_cpsr,
    output isa_pkg::word_t       data_addr,
    output logic                 data_read,
    output logic                 data_write,
    output isa_pkg::word_t       data_out,
    output ctrl_pkg::alu_op_e    opcode,
    output isa_pkg::word_t       operand2,
    output ctrl_pkg::opnd_src_e  ir_op,
    output logic                 wr_pc,
    output isa_pkg::word_t       wr_pc_val,
    output logic                 halt_flag
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_addr     <= '0;
            write_data     <= '0;
            write_data_sel <= ctrl_pkg::WR_ID;
            write_enable   <= 1'b0;
            wr_cpsr        <= 1'b0;
            data_addr      <= '0;
            data_read      <= 1'b0;
            data_write     <= 1'b0;
            data_out       <= '0;
            opcode         <= ctrl_pkg::ALU_NOP;
            operand2       <= '0;
            ir_op          <= ctrl_pkg::SRC_IMM;
            wr_pc          <= 1'b0;
            wr_pc_val      <= '0;
            halt_flag      <= 1'b0;
        end else begin
            // once halted every output falls back to its reset value
            write_addr     <= halt_flag ? '0 : write_addr_nxt;
            write_data     <= halt_flag ? '0 : write_data_nxt;
            write_data_sel <= halt_flag ? ctrl_pkg::WR_ID : write_data_sel_nxt;
            write_enable   <= ~halt_flag & write_enable_nxt;
            wr_cpsr        <= ~halt_flag & wr_cpsr_nxt;
            data_addr      <= halt_flag ? '0 : data_addr_nxt;
            data_read      <= ~halt_flag & data_read_nxt;
            data_write     <= ~halt_flag & data_write_nxt;
            data_out       <= halt_flag ? '0 : data_out_nxt;
            opcode         <= halt_flag ? ctrl_pkg::ALU_NOP : opcode_nxt;
            operand2       <= halt_flag ? '0 : operand2_nxt;
            ir_op          <= halt_flag ? ctrl_pkg::SRC_IMM : ir_op_nxt;
            wr_pc          <= ~halt_flag & wr_pc_nxt;
            wr_pc_val      <= halt_flag ? '0 : wr_pc_val_nxt;
            halt_flag      <= halt_flag | halt_req;     // sticky until reset
        end
    end

endmodule

// File: src/instr_decode.sv
// instruction decode stage, top level
module instr_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  isa_pkg::word_t       instruction,
    input  isa_pkg::word_t       reg1_val,        // returned in the same cycle
    input  isa_pkg::word_t       reg2_val,
    input  isa_pkg::word_t       re_cpsr_val,
    input  isa_pkg::word_t       re_pc_val,
    output isa_pkg::reg_addr_t   read_addr1,
    output isa_pkg::reg_addr_t   read_addr2,
    output isa_pkg::reg_addr_t   write_addr,
    output isa_pkg::word_t       write_data,
    output ctrl_pkg::wr_src_e    write_data_sel,
    output logic                 write_enable,
    output logic                 wr_cpsr,
    output isa_pkg::word_t       data_addr,
    output logic                 data_read,
    output logic                 data_write,
    output isa_pkg::word_t       data_out,
    output ctrl_pkg::alu_op_e    opcode,
    output isa_pkg::word_t       operand2,
    output ctrl_pkg::opnd_src_e  ir_op,
    output logic                 wr_pc,
    output isa_pkg::word_t       wr_pc_val,
    output logic                 halt_flag
);

    isa_pkg::reg_addr_t  write_addr_nxt;
    isa_pkg::word_t      write_data_nxt, data_addr_nxt, data_out_nxt;
    isa_pkg::word_t      operand2_nxt, wr_pc_val_nxt;
    ctrl_pkg::wr_src_e   write_data_sel_nxt;
    ctrl_pkg::alu_op_e   opcode_nxt;
    ctrl_pkg::opnd_src_e ir_op_nxt;
    ctrl_pkg::mov_kind_e mov_kind;
    logic                write_enable_nxt, wr_cpsr_nxt, data_read_nxt, data_write_nxt;
    logic                wr_pc_nxt, is_bcond, halt_req;

    ctrl_decode u_ctrl_decode (
        .instruction, .read_addr1, .read_addr2, .write_addr_nxt,
        .write_data_sel_nxt, .write_enable_nxt, .wr_cpsr_nxt, .opcode_nxt,
        .ir_op_nxt, .data_read_nxt, .data_write_nxt, .is_bcond, .halt_req, .mov_kind
    );

    id_datapath u_id_datapath (
        .instruction, .reg1_val, .reg2_val, .mov_kind, .data_read_nxt,
        .data_write_nxt, .write_data_sel_nxt, .ir_op_nxt, .write_data_nxt,
        .data_addr_nxt, .data_out_nxt, .operand2_nxt
    );

    branch_unit u_branch_unit (
        .instruction, .is_bcond, .re_cpsr_val, .re_pc_val, .wr_pc_nxt, .wr_pc_val_nxt
    );

    id_out_stage u_id_out_stage (
        .clk, .rst_n, .halt_req, .write_addr_nxt, .write_data_nxt, .write_data_sel_nxt,
        .write_enable_nxt, .wr_cpsr_nxt, .data_addr_nxt, .data_read_nxt,
        .data_write_nxt, .data_out_nxt, .opcode_nxt, .operand2_nxt, .ir_op_nxt,
        .wr_pc_nxt, .wr_pc_val_nxt, .write_addr, .write_data, .write_data_sel,
        .write_enable, .wr_cpsr, .data_addr, .data_read, .data_write, .data_out,
        .opcode, .operand2, .ir_op, .wr_pc, .wr_pc_val, .halt_flag
    );

endmodule

// File: bench/instr_decode_chk.sv
// decode stage protocol assertions
module instr_decode_chk (
    input logic clk,
    input logic rst_n,
    input logic write_enable,
    input logic wr_cpsr,
    input logic data_read,
    input logic data_write,
    input logic wr_pc,
    input logic halt_flag
);
    timeunit 1ns;
    timeprecision 100ps;

    int err_count = 0;                      // read back by the testbench at the end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_read && data_write))
        else begin
            err_count++;
            $error("data_read and data_write high together");
        end

    a_st_we_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_write && write_enable))
        else begin
            err_count++;
            $error("store raised write_enable");
        end

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halt_flag |=> halt_flag)
        else begin
            err_count++;
            $error("halt_flag dropped without reset");
        end

    // halted core sees no enables at all
    a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        halt_flag |-> !(write_enable || wr_cpsr || data_read || data_write || wr_pc))
        else begin
            err_count++;
            $error("enable output high while halted");
        end

endmodule

bind instr_decode instr_decode_chk u_chk (
    .clk, .rst_n, .write_enable, .wr_cpsr, .data_read, .data_write, .wr_pc, .halt_flag
);

// File: bench/instr_decode_tb.sv
// decode stage testbench
module instr_decode_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CYCLE_LIMIT = 2000;      // about ten times the instructions applied

    logic                 clk, rst_n;
    isa_pkg::word_t       instruction, reg1_val, reg2_val, re_cpsr_val, re_pc_val;
    isa_pkg::reg_addr_t   read_addr1, read_addr2, write_addr;
    isa_pkg::word_t       write_data, data_addr, data_out, operand2, wr_pc_val;
    ctrl_pkg::wr_src_e    write_data_sel;
    ctrl_pkg::alu_op_e    opcode;
    ctrl_pkg::opnd_src_e  ir_op;
    logic                 write_enable, wr_cpsr, data_read, data_write, wr_pc, halt_flag;

    // expected values, built per instruction from the decode rules
    isa_pkg::reg_addr_t   e_ra1, e_ra2, e_waddr;
    isa_pkg::word_t       e_wdata, e_daddr, e_dout, e_opnd2, e_pcval;
    ctrl_pkg::wr_src_e    e_wsel;
    ctrl_pkg::alu_op_e    e_op;
    ctrl_pkg::opnd_src_e  e_irop;
    logic                 e_we, e_cpsr, e_dread, e_dwrite, e_wrpc, e_halt;

    isa_pkg::word_t       rf [8];           // register file model
    isa_pkg::word_t       cpsr_v, pc_v;
    logic                 halt_now;         // halt already registered before this instr
    logic [31:0]          lfsr_state = 32'hcd0e_894b;
    int                   cycles = 0;

    instr_decode dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b)
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic cond_holds(input logic [3:0] cond, input isa_pkg::word_t psr);
        logic n, z, c, v;
        n = psr[31];
        z = psr[30];
        c = psr[29];
        v = psr[28];
        case (cond)
            isa_pkg::EQ: return z;
            isa_pkg::NE: return !z;
            isa_pkg::CS: return c;
            isa_pkg::CC: return !c;
            isa_pkg::MI: return n;
            isa_pkg::PL: return !n;
            isa_pkg::VS: return v;
            isa_pkg::VC: return !v;
            isa_pkg::HI: return c && !z;
            isa_pkg::LS: return !(c && !z);
            isa_pkg::GE: return n == v;
            isa_pkg::LT: return n != v;
            default:     return 1'b0;       // 12..15 never taken
        endcase
    endfunction

    task automatic check_word(input string name, input isa_pkg::word_t exp,
                              input isa_pkg::word_t act);
        if (act !== exp) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input isa_pkg::reg_addr_t exp,
                              input isa_pkg::reg_addr_t act);
        if (act !== exp) begin
            $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_alu_op(input string name, input ctrl_pkg::alu_op_e exp,
                                input ctrl_pkg::alu_op_e act);
        if (act !== exp) begin
            $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_opnd_src(input string name, input ctrl_pkg::opnd_src_e exp,
                                  input ctrl_pkg::opnd_src_e act);
        if (act !== exp) begin
            $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_wr_src(input string name, input ctrl_pkg::wr_src_e exp,
                                input ctrl_pkg::wr_src_e act);
        if (act !== exp) begin
            $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    // registered outputs only, read addresses stay as decoded
    task automatic zero_outputs();
        e_waddr = '0;
        e_wdata = '0;
        e_wsel  = ctrl_pkg::WR_ID;
        e_we    = 1'b0;
        e_cpsr  = 1'b0;
        e_daddr = '0;
        e_dread = 1'b0;
        e_dwrite = 1'b0;
        e_dout  = '0;
        e_op    = ctrl_pkg::ALU_NOP;
        e_opnd2 = '0;
        e_irop  = ctrl_pkg::SRC_IMM;
        e_wrpc  = 1'b0;
        e_pcval = '0;
    endtask

    task automatic clear_exp();
        e_ra1 = '0;
        e_ra2 = '0;
        zero_outputs();
    endtask

    task automatic fill_regs();
        for (int i = 0; i < 8; i++)
            rf[i] = rand_bits(32);
    endtask

    task automatic check_outputs();
        check_addr("write_addr", e_waddr, write_addr);
        check_word("write_data", e_wdata, write_data);
        check_wr_src("write_data_sel", e_wsel, write_data_sel);
        check_bit("write_enable", e_we, write_enable);
        check_bit("wr_cpsr", e_cpsr, wr_cpsr);
        check_word("data_addr", e_daddr, data_addr);
        check_bit("data_read", e_dread, data_read);
        check_bit("data_write", e_dwrite, data_write);
        check_word("data_out", e_dout, data_out);
        check_alu_op("opcode", e_op, opcode);
        check_word("operand2", e_opnd2, operand2);
        check_opnd_src("ir_op", e_irop, ir_op);
        check_bit("wr_pc", e_wrpc, wr_pc);
        check_word("wr_pc_val", e_pcval, wr_pc_val);
        check_bit("halt_flag", e_halt, halt_flag);
    endtask

    // entered 1 ns after an edge, leaves 1 ns after the next one
    task automatic apply(input isa_pkg::word_t instr);
        instruction = instr;
        reg1_val    = rf[e_ra1];            // register file answers same cycle
        reg2_val    = rf[e_ra2];
        re_cpsr_val = cpsr_v;
        re_pc_val   = pc_v;
        #1;
        check_addr("read_addr1", e_ra1, read_addr1);
        check_addr("read_addr2", e_ra2, read_addr2);
        if (halt_now)
            zero_outputs();
        @(posedge clk);
        #1;
        check_outputs();
    endtask

    task automatic do_reset();
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        e_halt   = 1'b0;
        halt_now = 1'b0;
    endtask

    task automatic run_alu(input logic [2:0] alu, input logic reg_form, input logic s);
        isa_pkg::reg_addr_t rd, ra, rb;
        isa_pkg::imm_t      imm;
        rd  = 3'(rand_bits(3));
        ra  = 3'(rand_bits(3));
        rb  = 3'(rand_bits(3));
        imm = 16'(rand_bits(16));
        fill_regs();
        clear_exp();
        e_op    = ctrl_pkg::alu_op_e'(alu);     // bits 27:25
        e_ra1   = ra;
        e_waddr = rd;
        e_wsel  = ctrl_pkg::WR_ALU;
        e_we    = 1'b1;
        e_cpsr  = s;
        if (reg_form) begin
            e_irop = ctrl_pkg::SRC_REG;
            e_ra2  = (alu == 3'd6) ? '0 : rb;   // not is unary
        end else begin
            e_opnd2 = {16'h0000, imm};
        end
        apply({reg_form ? 3'b011 : 3'b001, s, alu, rd, ra, rb, imm});
    endtask

    task automatic run_mem(input logic store);
        isa_pkg::reg_addr_t rd, ra, rb;
        isa_pkg::imm_t      imm;
        rd  = 3'(rand_bits(3));
        ra  = 3'(rand_bits(3));
        rb  = 3'(rand_bits(3));
        imm = 16'(rand_bits(16));
        fill_regs();
        clear_exp();
        e_daddr = rf[ra] + {16'h0000, imm};     // pointer plus zero extended offset
        if (store) begin
            e_ra1    = rd;
            e_ra2    = ra;
            e_dout   = rf[rd];
            e_dwrite = 1'b1;
            apply({isa_pkg::OP_STOR, rd, ra, rb, imm});
        end else begin
            e_ra1   = ra;
            e_dread = 1'b1;
            e_waddr = rd;
            e_wsel  = ctrl_pkg::WR_MEM;
            e_we    = 1'b1;
            apply({isa_pkg::OP_LOAD, rd, ra, rb, imm});
        end
    endtask

    task automatic run_bcond(input logic [3:0] cond, input logic neg);
        isa_pkg::imm_t off;
        logic [4:0]    spare;
        cpsr_v  = rand_bits(32);
        pc_v    = rand_bits(32);
        off     = 16'(rand_bits(16));
        spare   = 5'(rand_bits(5));
        off[15] = neg;                      // force backward branches half the time
        clear_exp();
        e_wrpc  = cond_holds(cond, cpsr_v);
        e_pcval = e_wrpc ? pc_v + {{16{off[15]}}, off} : '0;
        apply({isa_pkg::OP_BCOND, cond, spare, off});
    endtask

    task automatic test_reset_nop();
        clear_exp();
        check_outputs();
        apply({isa_pkg::OP_NOP, 25'd0});
        apply({isa_pkg::OP_B, 25'(rand_bits(25))});     // b and br are dead
        apply({isa_pkg::OP_BR, 25'(rand_bits(25))});
        apply({7'h7f, 25'(rand_bits(25))});
        apply({7'b0111110, 25'(rand_bits(25))});        // no flag-setting not
    endtask

    task automatic test_alu();
        for (int alu = 1; alu <= 6; alu++)
            for (int form = 0; form < 2; form++)
                for (int s = 0; s < 2; s++)
                    for (int k = 0; k < 3; k++)
                        if (alu != 6 || (form == 1 && s == 0))
                            run_alu(alu[2:0], form[0], s[0]);
    endtask

    task automatic test_moves();
        isa_pkg::reg_addr_t rd, ra, rb;
        isa_pkg::imm_t      imm;
        logic [6:0]         op;
        for (int k = 0; k < 24; k++) begin
            rd  = 3'(rand_bits(3));
            ra  = 3'(rand_bits(3));
            rb  = 3'(rand_bits(3));
            imm = 16'(rand_bits(16));
            fill_regs();
            clear_exp();
            e_waddr = rd;
            e_we    = 1'b1;
            case (k % 6)
                0: begin
                    op      = isa_pkg::OP_MOV;
                    e_ra1   = rd;
                    e_wdata = {rf[rd][31:16], imm};
                end
                1: begin
                    op      = isa_pkg::OP_MOVT;
                    e_ra1   = rd;
                    e_wdata = {imm, rf[rd][15:0]};
                end
                2: begin
                    op      = isa_pkg::OP_CLR;
                    e_wdata = '0;
                end
                3: begin
                    op      = isa_pkg::OP_SET;
                    e_wdata = '1;
                end
                4: begin
                    op      = isa_pkg::OP_LSL;
                    imm     = 16'(rand_bits(6));    // amounts past 31 clear the word
                    e_ra1   = ra;
                    e_wdata = rf[ra] << imm;
                end
                default: begin
                    op      = isa_pkg::OP_LSR;
                    imm     = 16'(rand_bits(6));
                    e_ra1   = ra;
                    e_wdata = rf[ra] >> imm;
                end
            endcase
            apply({op, rd, ra, rb, imm});
        end
    endtask

    task automatic test_memory();
        for (int k = 0; k < 16; k++)
            run_mem(k[0]);
    endtask

    task automatic test_branches();
        for (int c = 0; c < 16; c++)
            for (int k = 0; k < 6; k++)
                run_bcond(c[3:0], k[0]);
    endtask

    task automatic test_halt();
        clear_exp();
        e_halt = 1'b1;
        apply({isa_pkg::OP_HALT, 25'(rand_bits(25))});
        halt_now = 1'b1;
        run_alu(3'd1, 1'b0, 1'b1);
        run_alu(3'd2, 1'b1, 1'b0);
        run_mem(1'b1);
        run_mem(1'b0);
        for (int c = 0; c < 4; c++)
            run_bcond(c[3:0], c[0]);
        do_reset();
        clear_exp();
        check_outputs();
        run_alu(3'd5, 1'b0, 1'b0);          // decode resumes after reset
    endtask

    initial begin
        rst_n       = 1'b0;
        instruction = {isa_pkg::OP_NOP, 25'd0};
        reg1_val    = '0;
        reg2_val    = '0;
        re_cpsr_val = '0;
        re_pc_val   = '0;
        cpsr_v      = '0;
        pc_v        = '0;
        e_halt      = 1'b0;
        halt_now    = 1'b0;
        fill_regs();
        do_reset();
        test_reset_nop();
        test_alu();
        test_moves();
        test_memory();
        test_branches();
        test_halt();
        if (dut_i.u_chk.err_count != 0) begin
            $display("bound assertions failed %0d times", dut_i.u_chk.err_count);
            abort_run();
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// File: sources.f
+incdir+common
common/isa_pkg.sv
common/ctrl_pkg.sv
decoder/ctrl_decode.sv
decoder/branch_unit.sv
decoder/id_datapath.sv
decoder/id_out_stage.sv
src/instr_decode.sv
bench/instr_decode_chk.sv
bench/instr_decode_tb.sv
